/* common/mem_net_defines.svh */
/*
 * Memory network sizing
 * Port count, message field widths, bank select position, queue depth
 */

`ifndef MEM_NET_DEFINES_SVH
`define MEM_NET_DEFINES_SVH

// Ports on each side of both networks
`define MEM_NET_NUM_PORTS   4

// Memory message fields
`define MEM_NET_OPAQUE_BITS 4
`define MEM_NET_ADDR_BITS   32
`define MEM_NET_DATA_BITS   32

// 16-byte lines interleaved over the banks
`define MEM_NET_BANK_LSB    4

// Entries per crossbar input
`define MEM_NET_QUEUE_DEPTH 2

`endif

/* common/net_pkg.sv */
/*
 * Network types
 * Port index and input queue pointer types for the crossbars
 */

`include "mem_net_defines.svh"

package net_pkg;

  // Selects one of the ports on either side
  typedef logic [$clog2(`MEM_NET_NUM_PORTS)-1:0] port_idx_t;

  // Read and write pointers of an input queue
  typedef logic [$clog2(`MEM_NET_QUEUE_DEPTH)-1:0] queue_ptr_t;

endpackage

/* common/mem_msg_pkg.sv */
/*
 * Memory message types
 * Request and response layouts carried by the memory network
 */

`include "mem_net_defines.svh"

package mem_msg_pkg;

  // Access type code, same encoding for requests and responses
  typedef enum logic
  {
    mem_read  = 1'b0,
    mem_write = 1'b1
  } mem_type_e;

  // Request, 71 bits, type in the top bit
  typedef struct packed
  {
    mem_type_e                        mtype;
    logic [`MEM_NET_OPAQUE_BITS-1:0]  opaque;
    logic [`MEM_NET_ADDR_BITS-1:0]    addr;
    logic [1:0]                       len;
    logic [`MEM_NET_DATA_BITS-1:0]    data;
  } mem_req_t;

  // Response, 39 bits, no address
  typedef struct packed
  {
    mem_type_e                        mtype;
    logic [`MEM_NET_OPAQUE_BITS-1:0]  opaque;
    logic [1:0]                       len;
    logic [`MEM_NET_DATA_BITS-1:0]    data;
  } mem_resp_t;

endpackage

/* common/net_port_if.sv */
/*
 * Network port
 * Valid/ready channel carrying a message and its output port
 */

`timescale 1ns/1ps

interface net_port_if
#(
  parameter type payload_t = logic
);

  logic                val;
  logic                rdy;
  payload_t            msg;
  net_pkg::port_idx_t  dest;

  // Producer side
  modport send
  (
    output val,
    output msg,
    output dest,
    input  rdy
  );

  // Consumer side
  modport recv
  (
    input  val,
    input  msg,
    input  dest,
    output rdy
  );

endinterface

/* hw/xbar/xbar_in_queue.sv */
/*
 * Crossbar input queue
 * Two-entry circular buffer holding each message with its output port
 */

`timescale 1ns/1ps

`include "mem_net_defines.svh"

module xbar_in_queue
#(
  parameter type payload_t = logic
)
(
  input  logic        clk,
  input  logic        rst_n,
  net_port_if.recv    enq,
  net_port_if.send    deq
);

  localparam int DEPTH = `MEM_NET_QUEUE_DEPTH;

  payload_t                      msg_q  [DEPTH];
  net_pkg::port_idx_t            dest_q [DEPTH];

  net_pkg::queue_ptr_t           wr_ptr_q;
  net_pkg::queue_ptr_t           rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0]    count_q;

  logic                          enq_fire;
  logic                          deq_fire;

  // A full queue still accepts when its head leaves this cycle
  assign enq.rdy  = (count_q != DEPTH) || deq.rdy;
  assign enq_fire = enq.val && enq.rdy;
  assign deq_fire = deq.val && deq.rdy;

  assign deq.val  = (count_q != '0);
  assign deq.msg  = msg_q[rd_ptr_q];
  assign deq.dest = dest_q[rd_ptr_q];

  // ----------------------------------------------------------------------
  // Storage
  // ----------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (enq_fire)
    begin
      msg_q[wr_ptr_q]  <= enq.msg;
      dest_q[wr_ptr_q] <= enq.dest;
    end
  end

  // ----------------------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (enq_fire)
      begin
        wr_ptr_q <= (wr_ptr_q == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (deq_fire)
      begin
        rd_ptr_q <= (rd_ptr_q == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      // Count holds when both sides fire
      if (enq_fire && !deq_fire)
      begin
        count_q <= count_q + 1'b1;
      end
      else if (deq_fire && !enq_fire)
      begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

/* hw/xbar/xbar_arbiter.sv */
/*
 * Round-robin arbiter for one crossbar output
 * Grant is held while the granted transfer is stalled
 */

`timescale 1ns/1ps

`include "mem_net_defines.svh"

module xbar_arbiter
(
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [`MEM_NET_NUM_PORTS-1:0] req,
  input  logic                          advance,
  output logic [`MEM_NET_NUM_PORTS-1:0] grant
);

  localparam int NUM_PORTS = `MEM_NET_NUM_PORTS;

  net_pkg::port_idx_t  ptr_q;
  net_pkg::port_idx_t  grant_idx;
  logic                hold_q;
  net_pkg::port_idx_t  hold_idx_q;

  // First requester at or after the pointer wins, scanned from the far end
  always_comb
  begin
    grant_idx = ptr_q;
    for (int k = NUM_PORTS - 1; k >= 0; k--)
    begin
      if (req[(ptr_q + k) % NUM_PORTS])
      begin
        grant_idx = net_pkg::port_idx_t'((ptr_q + k) % NUM_PORTS);
      end
    end
    // Stalled winner keeps the output so its message stays put
    if (hold_q)
    begin
      grant_idx = hold_idx_q;
    end
    grant            = '0;
    grant[grant_idx] = req[grant_idx];
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      ptr_q  <= '0;
      hold_q <= 1'b0;
    end
    else
    begin
      hold_q <= (|grant) && !advance;
      if (advance)
      begin
        ptr_q <= net_pkg::port_idx_t'((grant_idx + 1) % NUM_PORTS);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    hold_idx_q <= grant_idx;
  end

endmodule

/* hw/xbar/msg_xbar.sv */
/*
 * Generic N-by-N message crossbar
 * Input queues, one round-robin arbiter and mux per output
 */

`timescale 1ns/1ps

`include "mem_net_defines.svh"

module msg_xbar
#(
  parameter type payload_t = logic
)
(
  input  logic                          clk,
  input  logic                          rst_n,
  net_port_if.recv                      in_port [`MEM_NET_NUM_PORTS],
  output logic [`MEM_NET_NUM_PORTS-1:0] out_val,
  input  logic [`MEM_NET_NUM_PORTS-1:0] out_rdy,
  output payload_t                      out_msg [`MEM_NET_NUM_PORTS]
);

  localparam int NUM_PORTS = `MEM_NET_NUM_PORTS;

  // Queue heads, one channel per input
  net_port_if #(.payload_t(payload_t)) head_if [NUM_PORTS] ();

  logic [NUM_PORTS-1:0]   head_val;
  logic [NUM_PORTS-1:0]   head_rdy;
  payload_t               head_msg  [NUM_PORTS];
  net_pkg::port_idx_t     head_dest [NUM_PORTS];

  // grant[o][i] set when output o takes input i
  logic [NUM_PORTS-1:0]   grant     [NUM_PORTS];

  // ----------------------------------------------------------------------
  // Input side
  // ----------------------------------------------------------------------

  for (genvar i = 0; i < NUM_PORTS; i++)
  begin : g_in
    logic take;

    xbar_in_queue #(.payload_t(payload_t)) u_queue
    (
      .clk   (clk),
      .rst_n (rst_n),
      .enq   (in_port[i]),
      .deq   (head_if[i])
    );

    assign head_val[i]  = head_if[i].val;
    assign head_msg[i]  = head_if[i].msg;
    assign head_dest[i] = head_if[i].dest;

    // Head leaves when its output grants it and can accept
    always_comb
    begin
      take = 1'b0;
      for (int o = 0; o < NUM_PORTS; o++)
      begin
        take = take | (grant[o][i] & out_rdy[o]);
      end
    end

    assign head_rdy[i]    = take;
    assign head_if[i].rdy = head_rdy[i];
  end

  // ----------------------------------------------------------------------
  // Output side
  // ----------------------------------------------------------------------

  for (genvar o = 0; o < NUM_PORTS; o++)
  begin : g_out
    logic [NUM_PORTS-1:0] req;
    payload_t             sel_msg;

    // Heads that want this output
    always_comb
    begin
      for (int i = 0; i < NUM_PORTS; i++)
      begin
        req[i] = head_val[i] && (head_dest[i] == net_pkg::port_idx_t'(o));
      end
    end

    xbar_arbiter u_arb
    (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (req),
      .advance (out_val[o] && out_rdy[o]),
      .grant   (grant[o])
    );

    // Grant is one-hot, so the last match is the only one
    always_comb
    begin
      sel_msg = head_msg[0];
      for (int i = 0; i < NUM_PORTS; i++)
      begin
        if (grant[o][i])
        begin
          sel_msg = head_msg[i];
        end
      end
    end

    assign out_val[o] = |grant[o];
    assign out_msg[o] = sel_msg;
  end

endmodule

/* hw/mem_net.sv */
/*
 * Memory request/response network
 * Requests routed to banks by address, responses back by opaque bits
 */

`timescale 1ns/1ps

`include "mem_net_defines.svh"

module mem_net
(
  input  logic                          clk,
  input  logic                          rst_n,

  // Processors to network
  input  logic [`MEM_NET_NUM_PORTS-1:0] req_in_val,
  output logic [`MEM_NET_NUM_PORTS-1:0] req_in_rdy,
  input  mem_msg_pkg::mem_req_t         req_in_msg   [`MEM_NET_NUM_PORTS],

  // Network to banks
  output logic [`MEM_NET_NUM_PORTS-1:0] req_out_val,
  input  logic [`MEM_NET_NUM_PORTS-1:0] req_out_rdy,
  output mem_msg_pkg::mem_req_t         req_out_msg  [`MEM_NET_NUM_PORTS],

  // Banks to network
  input  logic [`MEM_NET_NUM_PORTS-1:0] resp_in_val,
  output logic [`MEM_NET_NUM_PORTS-1:0] resp_in_rdy,
  input  mem_msg_pkg::mem_resp_t        resp_in_msg  [`MEM_NET_NUM_PORTS],

  // Network to processors
  output logic [`MEM_NET_NUM_PORTS-1:0] resp_out_val,
  input  logic [`MEM_NET_NUM_PORTS-1:0] resp_out_rdy,
  output mem_msg_pkg::mem_resp_t        resp_out_msg [`MEM_NET_NUM_PORTS]
);

  localparam int NUM_PORTS = `MEM_NET_NUM_PORTS;
  localparam int OPQ_BITS  = `MEM_NET_OPAQUE_BITS;
  localparam int BANK_LSB  = `MEM_NET_BANK_LSB;
  localparam int IDX_BITS  = $bits(net_pkg::port_idx_t);

  net_port_if #(.payload_t(mem_msg_pkg::mem_req_t))  req_if  [NUM_PORTS] ();
  net_port_if #(.payload_t(mem_msg_pkg::mem_resp_t)) resp_if [NUM_PORTS] ();

  // ----------------------------------------------------------------------
  // Request network
  // ----------------------------------------------------------------------

  for (genvar i = 0; i < NUM_PORTS; i++)
  begin : g_req
    mem_msg_pkg::mem_req_t fwd_msg;

    // Tag the request with its source so the response can find its way back
    always_comb
    begin
      fwd_msg = req_in_msg[i];
      fwd_msg.opaque[OPQ_BITS-1 -: IDX_BITS] = net_pkg::port_idx_t'(i);
    end

    assign req_if[i].val  = req_in_val[i];
    assign req_if[i].msg  = fwd_msg;
    // Bank from the line-interleave bits
    assign req_if[i].dest = req_in_msg[i].addr[BANK_LSB +: IDX_BITS];
    assign req_in_rdy[i]  = req_if[i].rdy;
  end

  msg_xbar #(.payload_t(mem_msg_pkg::mem_req_t)) u_req_xbar
  (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_port (req_if),
    .out_val (req_out_val),
    .out_rdy (req_out_rdy),
    .out_msg (req_out_msg)
  );

  // ----------------------------------------------------------------------
  // Response network
  // ----------------------------------------------------------------------

  for (genvar i = 0; i < NUM_PORTS; i++)
  begin : g_resp
    assign resp_if[i].val  = resp_in_val[i];
    assign resp_if[i].msg  = resp_in_msg[i];
    // Processor index sits in the top opaque bits
    assign resp_if[i].dest = resp_in_msg[i].opaque[OPQ_BITS-1 -: IDX_BITS];
    assign resp_in_rdy[i]  = resp_if[i].rdy;
  end

  msg_xbar #(.payload_t(mem_msg_pkg::mem_resp_t)) u_resp_xbar
  (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_port (resp_if),
    .out_val (resp_out_val),
    .out_rdy (resp_out_rdy),
    .out_msg (resp_out_msg)
  );

endmodule

/* sim/mem_net_sva.sv */
/*
 * Protocol checks on the memory network ports
 * Output hold under back-pressure and the state right after reset
 */

`timescale 1ns/1ps

`include "mem_net_defines.svh"

module mem_net_sva
(
  input logic                          clk,
  input logic                          rst_n,
  input logic [`MEM_NET_NUM_PORTS-1:0] req_in_rdy,
  input logic [`MEM_NET_NUM_PORTS-1:0] resp_in_rdy,
  input logic [`MEM_NET_NUM_PORTS-1:0] req_out_val,
  input logic [`MEM_NET_NUM_PORTS-1:0] req_out_rdy,
  input mem_msg_pkg::mem_req_t         req_out_msg  [`MEM_NET_NUM_PORTS],
  input logic [`MEM_NET_NUM_PORTS-1:0] resp_out_val,
  input logic [`MEM_NET_NUM_PORTS-1:0] resp_out_rdy,
  input mem_msg_pkg::mem_resp_t        resp_out_msg [`MEM_NET_NUM_PORTS]
);

  // Failed assertions, read by the testbench at the end of the run
  int fail_cnt = 0;

  // Reset drains both networks and opens every input
  assert property (@(posedge clk) !rst_n |=>
                   (req_out_val == '0) && (resp_out_val == '0) &&
                   (&req_in_rdy) && (&resp_in_rdy))
  else
  begin
    $error("outputs not idle or inputs not ready after reset");
    fail_cnt++;
  end

  for (genvar p = 0; p < `MEM_NET_NUM_PORTS; p++)
  begin : g_port
    // Stalled output keeps its message
    assert property (@(posedge clk) disable iff (!rst_n)
                     req_out_val[p] && !req_out_rdy[p] |=>
                     req_out_val[p] && $stable(req_out_msg[p]))
    else
    begin
      $error("request output %0d changed while stalled", p);
      fail_cnt++;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
                     resp_out_val[p] && !resp_out_rdy[p] |=>
                     resp_out_val[p] && $stable(resp_out_msg[p]))
    else
    begin
      $error("response output %0d changed while stalled", p);
      fail_cnt++;
    end
  end

endmodule

bind mem_net mem_net_sva u_sva
(
  .clk          (clk),
  .rst_n        (rst_n),
  .req_in_rdy   (req_in_rdy),
  .resp_in_rdy  (resp_in_rdy),
  .req_out_val  (req_out_val),
  .req_out_rdy  (req_out_rdy),
  .req_out_msg  (req_out_msg),
  .resp_out_val (resp_out_val),
  .resp_out_rdy (resp_out_rdy),
  .resp_out_msg (resp_out_msg)
);

/* sim/mem_net_tb.sv */
/*
 * Memory network testbench
 * Directed, random and hotspot traffic against a per-pair scoreboard
 */

`timescale 1ns/1ps

`include "mem_net_defines.svh"

module mem_net_tb;

  localparam int NP         = `MEM_NET_NUM_PORTS;
  localparam int OPQ_BITS   = `MEM_NET_OPAQUE_BITS;
  localparam int BANK_LSB   = `MEM_NET_BANK_LSB;
  localparam int IDX_BITS   = $clog2(NP);
  localparam int TOTAL_MSGS = 11 + 13 + 64 + 64 + 32 + 32;
  localparam int MAX_CYCLES = 20 * TOTAL_MSGS + 200;

  logic                    clk;
  logic                    rst_n;
  logic [NP-1:0]           req_in_val;
  logic [NP-1:0]           req_in_rdy;
  mem_msg_pkg::mem_req_t   req_in_msg   [NP];
  logic [NP-1:0]           req_out_val;
  logic [NP-1:0]           req_out_rdy;
  mem_msg_pkg::mem_req_t   req_out_msg  [NP];
  logic [NP-1:0]           resp_in_val;
  logic [NP-1:0]           resp_in_rdy;
  mem_msg_pkg::mem_resp_t  resp_in_msg  [NP];
  logic [NP-1:0]           resp_out_val;
  logic [NP-1:0]           resp_out_rdy;
  mem_msg_pkg::mem_resp_t  resp_out_msg [NP];

  // Expected messages, one queue per source and destination pair
  mem_msg_pkg::mem_req_t   req_exp  [NP*NP][$];
  mem_msg_pkg::mem_resp_t  resp_exp [NP*NP][$];

  logic [31:0]             rng = 32'he972;
  int                      cycle_cnt = 0;
  int                      err_cnt = 0;
  int                      tx_cnt = 0;
  int                      rx_cnt = 0;
  int                      req_left  [NP];
  int                      resp_left [NP];
  int                      req_idx   [NP];
  int                      resp_idx  [NP];

  mem_net u_mem_net (.*);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES)
    begin
      $display("Timeout: traffic still pending after %0d cycles", MAX_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------------------

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  // Mode 0 directed, 1 random, 2 hotspot on bank 0 and processor 0
  function automatic mem_msg_pkg::mem_req_t make_req(input int mode, input int p, input int k);
    mem_msg_pkg::mem_req_t m;
    m.mtype  = mem_msg_pkg::mem_type_e'(k % 2);
    m.opaque = OPQ_BITS'(k);
    m.len    = 2'(k);
    m.addr   = 32'h0000_1000 + 32'((k * NP + p + k) * 16);
    m.data   = 32'hd0d0_0000 + 32'(k * 256 + p);
    if (mode != 0)
    begin
      m.mtype  = mem_msg_pkg::mem_type_e'(next_rand() % 2);
      m.opaque = OPQ_BITS'(next_rand());
      m.addr   = next_rand();
      m.data   = next_rand();
    end
    if (mode == 2)
      m.addr[BANK_LSB +: IDX_BITS] = '0;
    return m;
  endfunction

  function automatic mem_msg_pkg::mem_resp_t make_resp(input int mode, input int p,
                                                       input int k);
    mem_msg_pkg::mem_resp_t m;
    m.mtype  = mem_msg_pkg::mem_type_e'(k % 2);
    m.opaque = {IDX_BITS'(p + k + 1), 2'(k)};
    m.len    = 2'(k + 1);
    m.data   = 32'hc0de_0000 + 32'(k * 16 + p);
    if (mode != 0)
    begin
      m.opaque = OPQ_BITS'(next_rand());
      m.data   = next_rand();
    end
    if (mode == 2)
      m.opaque[OPQ_BITS-1 -: IDX_BITS] = '0;
    return m;
  endfunction

  function automatic logic [NP-1:0] pick_rdy(input int mode);
    logic [31:0] r;
    r = next_rand();
    if (mode == 1)
      return NP'(r) | NP'(r >> 8);
    if (mode == 2)
      return ((cycle_cnt % 16) < 10) ? '1 : '0;
    return '1;
  endfunction

  // New message on each input whose slot frees up at this edge
  task automatic drive_cycle(input int mode);
    for (int p = 0; p < NP; p++)
    begin
      if (!req_in_val[p] || req_in_rdy[p])
      begin
        if (req_left[p] > 0 && (mode != 1 || next_rand() % 4 != 0))
        begin
          req_in_msg[p] <= make_req(mode, p, req_idx[p]);
          req_in_val[p] <= 1'b1;
          req_left[p]--;
          req_idx[p]++;
        end
        else
          req_in_val[p] <= 1'b0;
      end
      if (!resp_in_val[p] || resp_in_rdy[p])
      begin
        if (resp_left[p] > 0 && (mode != 1 || next_rand() % 4 != 0))
        begin
          resp_in_msg[p] <= make_resp(mode, p, resp_idx[p]);
          resp_in_val[p] <= 1'b1;
          resp_left[p]--;
          resp_idx[p]++;
        end
        else
          resp_in_val[p] <= 1'b0;
      end
    end
    req_out_rdy  <= pick_rdy(mode);
    resp_out_rdy <= pick_rdy(mode);
  endtask

  // ----------------------------------------------------------------------
  // Scoreboard
  // ----------------------------------------------------------------------

  task automatic expect_req(input int src, input mem_msg_pkg::mem_req_t m);
    mem_msg_pkg::mem_req_t exp;
    exp = m;
    exp.opaque[OPQ_BITS-1 -: IDX_BITS] = IDX_BITS'(src);
    req_exp[src * NP + int'(m.addr[BANK_LSB +: IDX_BITS])].push_back(exp);
    tx_cnt++;
  endtask

  task automatic check_req(input int dest, input mem_msg_pkg::mem_req_t m);
    int q;
    q = int'(m.opaque[OPQ_BITS-1 -: IDX_BITS]) * NP + dest;
    rx_cnt++;
    assert (req_exp[q].size() != 0 && m == req_exp[q][0])
    else
    begin
      $display("[ERROR] %0t: bank port %0d got unexpected request %h", $time, dest, m);
      err_cnt++;
    end
    if (req_exp[q].size() != 0)
      void'(req_exp[q].pop_front());
  endtask

  task automatic check_resp(input int dest, input mem_msg_pkg::mem_resp_t m);
    int hit;
    hit = -1;
    rx_cnt++;
    for (int s = NP - 1; s >= 0; s--)
    begin
      if (resp_exp[s * NP + dest].size() != 0 && resp_exp[s * NP + dest][0] == m)
        hit = s;
    end
    assert (hit >= 0)
    else
    begin
      $display("[ERROR] %0t: processor port %0d got unexpected response %h", $time, dest, m);
      err_cnt++;
    end
    if (hit >= 0)
      void'(resp_exp[hit * NP + dest].pop_front());
  endtask

  always @(posedge clk)
  begin
    if (rst_n)
    begin
      for (int p = 0; p < NP; p++)
      begin
        if (req_in_val[p] && req_in_rdy[p])
          expect_req(p, req_in_msg[p]);
        if (resp_in_val[p] && resp_in_rdy[p])
        begin
          resp_exp[p * NP + int'(resp_in_msg[p].opaque[OPQ_BITS-1 -: IDX_BITS])]
            .push_back(resp_in_msg[p]);
          tx_cnt++;
        end
        if (req_out_val[p] && req_out_rdy[p])
          check_req(p, req_out_msg[p]);
        if (resp_out_val[p] && resp_out_rdy[p])
          check_resp(p, resp_out_msg[p]);
      end
    end
  end

  function automatic int pending();
    int n;
    n = 0;
    for (int q = 0; q < NP * NP; q++)
      n += req_exp[q].size() + resp_exp[q].size();
    return n;
  endfunction

  function automatic int error_total();
    return err_cnt + u_mem_net.u_sva.fail_cnt;
  endfunction

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------

  int test_cnt = 0;
  int failed_cnt = 0;

  task automatic run_test(input string name, input int mode, input int n_req,
                          input int n_resp);
    int err0;
    int tx0;
    int rx0;
    logic idle;
    err0 = error_total();
    tx0  = tx_cnt;
    rx0  = rx_cnt;
    idle = 1'b0;
    for (int p = 0; p < NP; p++)
    begin
      req_left[p]  = n_req / NP + ((p < n_req % NP) ? 1 : 0);
      resp_left[p] = n_resp / NP + ((p < n_resp % NP) ? 1 : 0);
      req_idx[p]   = 0;
      resp_idx[p]  = 0;
    end
    while (!idle)
    begin
      @(posedge clk);
      drive_cycle(mode);
      #1;
      idle = (req_in_val == '0) && (resp_in_val == '0) && (tx_cnt == rx_cnt) &&
             (req_left.sum() == 0) && (resp_left.sum() == 0);
    end
    repeat (5) @(posedge clk);
    assert (pending() == 0)
    else
    begin
      $display("[ERROR] %0t: %0d messages left in the scoreboard", $time, pending());
      err_cnt++;
    end
    test_cnt++;
    if (error_total() != err0)
      failed_cnt++;
    $display("Test %0d %s: %0d in, %0d out, %0d errors", test_cnt, name,
             tx_cnt - tx0, rx_cnt - rx0, error_total() - err0);
  endtask

  initial
  begin
    rst_n        = 1'b0;
    req_in_val   = '0;
    resp_in_val  = '0;
    req_out_rdy  = '0;
    resp_out_rdy = '0;
    for (int p = 0; p < NP; p++)
    begin
      req_in_msg[p]  = '0;
      resp_in_msg[p] = '0;
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    run_test("directed", 0, 11, 13);
    run_test("random", 1, 64, 64);
    run_test("hotspot", 2, 32, 32);

    $display("Summary: %0d tests, %0d failed, %0d messages, %0d errors",
             test_cnt, failed_cnt, tx_cnt, error_total());
    if (error_total() == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

/* list.f */
+incdir+common
common/net_pkg.sv
common/mem_msg_pkg.sv
common/net_port_if.sv
hw/xbar/xbar_in_queue.sv
hw/xbar/xbar_arbiter.sv
hw/xbar/msg_xbar.sv
hw/mem_net.sv
sim/mem_net_sva.sv
sim/mem_net_tb.sv
